// ==== design/zd_pkg.sv ====
// ======================================================================
// Address map of the fabric. Each RAM bank holds 4 KB and appears
// repeatedly (aliased) across its 64 KB region.
// ======================================================================
package zd_pkg;

  // Bus widths
  localparam int ADDR_W = 24;
  localparam int DATA_W = 32;
  localparam int MASK_W = DATA_W / 8;

  // RAM banks
  localparam int BANK_WORDS = 1024;
  localparam int BANK_AW    = $clog2(BANK_WORDS);

  // Region field at address bits 17:16 with code 3 unmapped
  localparam int         REGION_LSB   = 16;
  localparam logic [1:0] REGION_BANK0 = 2'd0;
  localparam logic [1:0] REGION_BANK1 = 2'd1;
  localparam logic [1:0] REGION_SYS   = 2'd2;

  // General-purpose register block
  localparam int GPIO_N = 12;

  // Word offsets from address bits 3:2
  localparam logic [1:0] GPREG_DIR     = 2'd0;
  localparam logic [1:0] GPREG_OUT     = 2'd1;
  localparam logic [1:0] GPREG_IN      = 2'd2;
  localparam logic [1:0] GPREG_SCRATCH = 2'd3;

endpackage

// ==== design/zd_sram_bank.sv ====
// ======================================================================
// Read-before-write RAM. rdata_o holds the old word after a write.
// Contents are undefined until written.
// ======================================================================
module zd_sram_bank (
  input  logic                       clk,
  input  logic                       en_i,
  input  logic                       we_i,
  input  logic [zd_pkg::BANK_AW-1:0] addr_i,
  input  logic [zd_pkg::MASK_W-1:0]  mask_i,
  input  logic [zd_pkg::DATA_W-1:0]  wdata_i,
  output logic [zd_pkg::DATA_W-1:0]  rdata_o
);
import zd_pkg::*;

logic [DATA_W-1:0] mem [BANK_WORDS];

always_ff @(posedge clk) begin
  if (en_i) begin
    // Byte lanes enabled by the mask
    if (we_i) begin
      for (int b = 0; b < MASK_W; b++) begin
        if (mask_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
    rdata_o <= mem[addr_i];
  end
end

endmodule

// ==== design/zd_bank_arbiter.sv ====
// ======================================================================
// One bank, two masters. Requests must already be qualified by region;
// a bank access is acked one cycle after its grant.
// ======================================================================
module zd_bank_arbiter (
  input  logic                       clk,
  input  logic                       RSTN,
  input  logic                       i_req_i,
  input  logic [zd_pkg::ADDR_W-1:0]  i_addr_i,
  input  logic                       d_req_i,
  input  logic                       d_we_i,
  input  logic [zd_pkg::MASK_W-1:0]  d_mask_i,
  input  logic [zd_pkg::DATA_W-1:0]  d_wdata_i,
  input  logic [zd_pkg::ADDR_W-1:0]  d_addr_i,
  output logic                       i_ack_o,
  output logic                       d_ack_o,
  output logic                       d_sel_o,
  output logic                       mem_en_o,
  output logic                       mem_we_o,
  output logic [zd_pkg::BANK_AW-1:0] mem_addr_o,
  output logic [zd_pkg::MASK_W-1:0]  mem_mask_o,
  output logic [zd_pkg::DATA_W-1:0]  mem_wdata_o
);
import zd_pkg::*;

logic busy;
logic own_d;
logic last_d;
logic i_eff;
logic d_eff;
logic grant_d;

// The owner is acked in the busy cycle and still holds its req there
assign i_eff = i_req_i && !(busy && !own_d);
assign d_eff = d_req_i && !(busy && own_d);

// Contested grant goes to the loser of the previous contest
assign grant_d = d_eff && (!i_eff || !last_d);

assign mem_en_o    = i_eff || d_eff;
assign mem_we_o    = grant_d && d_we_i;
assign mem_addr_o  = grant_d ? d_addr_i[BANK_AW+1:2] : i_addr_i[BANK_AW+1:2];
assign mem_mask_o  = grant_d ? d_mask_i : '0;
assign mem_wdata_o = d_wdata_i;

always_ff @(posedge clk or negedge RSTN) begin
  if (!RSTN) begin
    busy   <= 1'b0;
    own_d  <= 1'b0;
    // Cleared so that data wins the first contest
    last_d <= 1'b0;
  end else begin
    busy <= mem_en_o;
    if (mem_en_o) begin
      own_d <= grant_d;
    end
    if (i_eff && d_eff) begin
      last_d <= grant_d;
    end
  end
end

assign i_ack_o = busy && !own_d;
assign d_ack_o = busy && own_d;
assign d_sel_o = own_d;

// ======================================================================
// Checks
// ======================================================================

// The owner still requests in its ack cycle
assert property (@(posedge clk) disable iff (!RSTN)
  busy |-> (own_d ? d_req_i : i_req_i));

// The master left waiting by a contest keeps its request
assert property (@(posedge clk) disable iff (!RSTN)
  (i_eff && d_eff) |=> (own_d ? i_req_i : d_req_i));

endmodule

// ==== design/zd_gpreg.sv ====
// ======================================================================
// GPIO direction, output and input plus a scratch word. The input goes
// through two flops, so it reads back two cycles after a change.
// ======================================================================
module zd_gpreg (
  input  logic                      clk,
  input  logic                      RSTN,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic [1:0]                adr_i,
  input  logic [zd_pkg::DATA_W-1:0] dat_i,
  output logic [zd_pkg::DATA_W-1:0] dat_o,
  output logic                      ack_o,
  output logic [zd_pkg::GPIO_N-1:0] gpio_dir_o,
  output logic [zd_pkg::GPIO_N-1:0] gpio_out_o,
  input  logic [zd_pkg::GPIO_N-1:0] gpio_in_i
);
import zd_pkg::*;

logic [GPIO_N-1:0] in_meta;
logic [GPIO_N-1:0] in_sync;
logic [DATA_W-1:0] scratch_q;
logic [DATA_W-1:0] rd_mux;
logic              access;

// Only the first cycle of a strobe counts
assign access = stb_i && !ack_o;

always_ff @(posedge clk or negedge RSTN) begin
  if (!RSTN) begin
    ack_o      <= 1'b0;
    gpio_dir_o <= '0;
    gpio_out_o <= '0;
  end else begin
    ack_o <= access;
    if (access && we_i && (adr_i == GPREG_DIR)) gpio_dir_o <= dat_i[GPIO_N-1:0];
    if (access && we_i && (adr_i == GPREG_OUT)) gpio_out_o <= dat_i[GPIO_N-1:0];
  end
end

always_ff @(posedge clk) begin
  in_meta <= gpio_in_i;
  in_sync <= in_meta;
  if (access && we_i && (adr_i == GPREG_SCRATCH)) scratch_q <= dat_i;
  if (access) dat_o <= rd_mux;
end

always_comb begin
  case (adr_i)
    GPREG_DIR: rd_mux = DATA_W'(gpio_dir_o);
    GPREG_OUT: rd_mux = DATA_W'(gpio_out_o);
    GPREG_IN:  rd_mux = DATA_W'(in_sync);
    default:   rd_mux = scratch_q;
  endcase
end

// A strobe stays up with the same access through its ack cycle
assert property (@(posedge clk) disable iff (!RSTN)
  (stb_i && !ack_o) |=> (stb_i && $stable(adr_i) && $stable(we_i)));

endmodule

// ==== design/zd_xbar.sv ====
// ======================================================================
// Region decode for both masters. Instruction fetches only reach RAM;
// anything unmapped is acked one cycle later with zero data.
// ======================================================================
module zd_xbar (
  input  logic                       clk,
  input  logic                       RSTN,
  input  logic                       instr_req_i,
  input  logic [zd_pkg::ADDR_W-1:0]  instr_addr_i,
  output logic [zd_pkg::DATA_W-1:0]  instr_rdata_o,
  output logic                       instr_ack_o,
  input  logic                       data_req_i,
  input  logic [zd_pkg::ADDR_W-1:0]  data_addr_i,
  input  logic                       data_we_i,
  input  logic [zd_pkg::MASK_W-1:0]  data_mask_i,
  input  logic [zd_pkg::DATA_W-1:0]  data_wdata_i,
  output logic [zd_pkg::DATA_W-1:0]  data_rdata_o,
  output logic                       data_ack_o,
  output logic                       bank0_en_o,
  output logic                       bank0_we_o,
  output logic [zd_pkg::BANK_AW-1:0] bank0_addr_o,
  output logic [zd_pkg::MASK_W-1:0]  bank0_mask_o,
  output logic [zd_pkg::DATA_W-1:0]  bank0_wdata_o,
  input  logic [zd_pkg::DATA_W-1:0]  bank0_rdata_i,
  output logic                       bank1_en_o,
  output logic                       bank1_we_o,
  output logic [zd_pkg::BANK_AW-1:0] bank1_addr_o,
  output logic [zd_pkg::MASK_W-1:0]  bank1_mask_o,
  output logic [zd_pkg::DATA_W-1:0]  bank1_wdata_o,
  input  logic [zd_pkg::DATA_W-1:0]  bank1_rdata_i,
  output logic                       sys_stb_o,
  output logic                       sys_we_o,
  output logic [1:0]                 sys_adr_o,
  output logic [zd_pkg::DATA_W-1:0]  sys_wdat_o,
  input  logic [zd_pkg::DATA_W-1:0]  sys_rdat_i,
  input  logic                       sys_ack_i
);
import zd_pkg::*;

logic [1:0] instr_region;
logic [1:0] data_region;
logic       instr_null;
logic       data_sys;
logic       data_null;
logic       instr_null_ack;
logic       data_null_ack;
logic       b0_i_ack, b0_d_ack, b0_d_sel;
logic       b1_i_ack, b1_d_ack, b1_d_sel;

assign instr_region = instr_addr_i[REGION_LSB +: 2];
assign data_region  = data_addr_i[REGION_LSB +: 2];

assign instr_null = (instr_region != REGION_BANK0) && (instr_region != REGION_BANK1);
assign data_sys   = (data_region == REGION_SYS);
assign data_null  = !data_sys && (data_region != REGION_BANK0)
                    && (data_region != REGION_BANK1);

// ======================================================================
// RAM banks
// ======================================================================
zd_bank_arbiter u_arb0 (
  .clk        (clk                                         ),
  .RSTN       (RSTN                                        ),
  .i_req_i    (instr_req_i && (instr_region == REGION_BANK0)),
  .i_addr_i   (instr_addr_i                                ),
  .d_req_i    (data_req_i && (data_region == REGION_BANK0)  ),
  .d_we_i     (data_we_i                                   ),
  .d_mask_i   (data_mask_i                                 ),
  .d_wdata_i  (data_wdata_i                                ),
  .d_addr_i   (data_addr_i                                 ),
  .i_ack_o    (b0_i_ack                                    ),
  .d_ack_o    (b0_d_ack                                    ),
  .d_sel_o    (b0_d_sel                                    ),
  .mem_en_o   (bank0_en_o                                  ),
  .mem_we_o   (bank0_we_o                                  ),
  .mem_addr_o (bank0_addr_o                                ),
  .mem_mask_o (bank0_mask_o                                ),
  .mem_wdata_o(bank0_wdata_o                               )
);

zd_bank_arbiter u_arb1 (
  .clk        (clk                                         ),
  .RSTN       (RSTN                                        ),
  .i_req_i    (instr_req_i && (instr_region == REGION_BANK1)),
  .i_addr_i   (instr_addr_i                                ),
  .d_req_i    (data_req_i && (data_region == REGION_BANK1)  ),
  .d_we_i     (data_we_i                                   ),
  .d_mask_i   (data_mask_i                                 ),
  .d_wdata_i  (data_wdata_i                                ),
  .d_addr_i   (data_addr_i                                 ),
  .i_ack_o    (b1_i_ack                                    ),
  .d_ack_o    (b1_d_ack                                    ),
  .d_sel_o    (b1_d_sel                                    ),
  .mem_en_o   (bank1_en_o                                  ),
  .mem_we_o   (bank1_we_o                                  ),
  .mem_addr_o (bank1_addr_o                                ),
  .mem_mask_o (bank1_mask_o                                ),
  .mem_wdata_o(bank1_wdata_o                               )
);

// ======================================================================
// System path and unmapped accesses
// ======================================================================
always_ff @(posedge clk or negedge RSTN) begin
  if (!RSTN) begin
    instr_null_ack <= 1'b0;
    data_null_ack  <= 1'b0;
    sys_stb_o      <= 1'b0;
  end else begin
    instr_null_ack <= instr_req_i && instr_null && !instr_null_ack;
    data_null_ack  <= data_req_i && data_null && !data_null_ack;
    // Strobe held until the register block acks
    if (sys_stb_o) begin
      sys_stb_o <= !sys_ack_i;
    end else begin
      sys_stb_o <= data_req_i && data_sys;
    end
  end
end

// Access captured along with the strobe
always_ff @(posedge clk) begin
  if (!sys_stb_o) begin
    sys_we_o   <= data_we_i;
    sys_adr_o  <= data_addr_i[3:2];
    sys_wdat_o <= data_wdata_i;
  end
end

assign instr_ack_o = b0_i_ack || b1_i_ack || instr_null_ack;
assign data_ack_o  = b0_d_ack || b1_d_ack || sys_ack_i || data_null_ack;

// Steer each bank to the owner of its completing access
always_comb begin
  instr_rdata_o = '0;
  data_rdata_o  = '0;
  if (b0_i_ack || b0_d_ack) begin
    if (b0_d_sel) data_rdata_o = bank0_rdata_i;
    else instr_rdata_o = bank0_rdata_i;
  end
  if (b1_i_ack || b1_d_ack) begin
    if (b1_d_sel) data_rdata_o = bank1_rdata_i;
    else instr_rdata_o = bank1_rdata_i;
  end
  if (sys_ack_i) data_rdata_o = sys_rdat_i;
end

// At most one ack source per master in any cycle
assert property (@(posedge clk) disable iff (!RSTN)
  $onehot0({b0_i_ack, b1_i_ack, instr_null_ack}));
assert property (@(posedge clk) disable iff (!RSTN)
  $onehot0({b0_d_ack, b1_d_ack, sys_ack_i, data_null_ack}));

endmodule

// ==== design/zd_top.sv ====
// ======================================================================
// Memory and system-bus fabric. The two master ports stand in for the
// CPU core; GPIO pads are left to the next level up.
// ======================================================================
module zd_top (
  input  logic                      RSTN,
  input  logic                      clk,
  input  logic                      instr_req_i,
  input  logic [zd_pkg::ADDR_W-1:0] instr_addr_i,
  output logic [zd_pkg::DATA_W-1:0] instr_rdata_o,
  output logic                      instr_ack_o,
  input  logic                      data_req_i,
  input  logic [zd_pkg::ADDR_W-1:0] data_addr_i,
  input  logic                      data_we_i,
  input  logic [zd_pkg::MASK_W-1:0] data_mask_i,
  input  logic [zd_pkg::DATA_W-1:0] data_wdata_i,
  output logic [zd_pkg::DATA_W-1:0] data_rdata_o,
  output logic                      data_ack_o,
  output logic [zd_pkg::GPIO_N-1:0] gpio_dir_o,
  output logic [zd_pkg::GPIO_N-1:0] gpio_out_o,
  input  logic [zd_pkg::GPIO_N-1:0] gpio_in_i
);
import zd_pkg::*;

logic               bank0_en, bank0_we, bank1_en, bank1_we;
logic [BANK_AW-1:0] bank0_addr, bank1_addr;
logic [MASK_W-1:0]  bank0_mask, bank1_mask;
logic [DATA_W-1:0]  bank0_wdata, bank0_rdata, bank1_wdata, bank1_rdata;
logic               sys_stb, sys_we, sys_ack;
logic [1:0]         sys_adr;
logic [DATA_W-1:0]  sys_wdat, sys_rdat;

zd_xbar u_xbar (
  .clk          (clk          ), .RSTN        (RSTN        ),
  .instr_req_i  (instr_req_i  ), .instr_addr_i(instr_addr_i),
  .instr_rdata_o(instr_rdata_o), .instr_ack_o (instr_ack_o ),
  .data_req_i   (data_req_i   ), .data_addr_i (data_addr_i ),
  .data_we_i    (data_we_i    ), .data_mask_i (data_mask_i ),
  .data_wdata_i (data_wdata_i ), .data_rdata_o(data_rdata_o),
  .data_ack_o   (data_ack_o   ),
  .bank0_en_o   (bank0_en     ), .bank0_we_o  (bank0_we    ),
  .bank0_addr_o (bank0_addr   ), .bank0_mask_o(bank0_mask  ),
  .bank0_wdata_o(bank0_wdata  ), .bank0_rdata_i(bank0_rdata),
  .bank1_en_o   (bank1_en     ), .bank1_we_o  (bank1_we    ),
  .bank1_addr_o (bank1_addr   ), .bank1_mask_o(bank1_mask  ),
  .bank1_wdata_o(bank1_wdata  ), .bank1_rdata_i(bank1_rdata),
  .sys_stb_o    (sys_stb      ), .sys_we_o    (sys_we      ),
  .sys_adr_o    (sys_adr      ), .sys_wdat_o  (sys_wdat    ),
  .sys_rdat_i   (sys_rdat     ), .sys_ack_i   (sys_ack     )
);

zd_sram_bank u_bank0 (
  .clk   (clk        ), .en_i   (bank0_en   ), .we_i   (bank0_we   ),
  .addr_i(bank0_addr ), .mask_i (bank0_mask ), .wdata_i(bank0_wdata),
  .rdata_o(bank0_rdata)
);

zd_sram_bank u_bank1 (
  .clk   (clk        ), .en_i   (bank1_en   ), .we_i   (bank1_we   ),
  .addr_i(bank1_addr ), .mask_i (bank1_mask ), .wdata_i(bank1_wdata),
  .rdata_o(bank1_rdata)
);

zd_gpreg u_gpreg (
  .clk       (clk       ), .RSTN      (RSTN      ),
  .stb_i     (sys_stb   ), .we_i      (sys_we    ),
  .adr_i     (sys_adr   ), .dat_i     (sys_wdat  ),
  .dat_o     (sys_rdat  ), .ack_o     (sys_ack   ),
  .gpio_dir_o(gpio_dir_o), .gpio_out_o(gpio_out_o),
  .gpio_in_i (gpio_in_i )
);

endmodule

// ==== verification/zd_tb.sv ====
// ======================================================================
// Replays verification/zd_golden.txt, one paired access per line.
// RAM words are only read after the file has written them.
// ======================================================================
module zd_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import zd_pkg::*;

  localparam int LINES          = 20;
  localparam int FIELDS         = 10;
  localparam int TIMEOUT_CYCLES = 20;

  logic              clk = 1'b0;
  logic              RSTN;
  logic              instr_req_i;
  logic [ADDR_W-1:0] instr_addr_i;
  logic [DATA_W-1:0] instr_rdata_o;
  logic              instr_ack_o;
  logic              data_req_i;
  logic [ADDR_W-1:0] data_addr_i;
  logic              data_we_i;
  logic [MASK_W-1:0] data_mask_i;
  logic [DATA_W-1:0] data_wdata_i;
  logic [DATA_W-1:0] data_rdata_o;
  logic              data_ack_o;
  logic [GPIO_N-1:0] gpio_dir_o;
  logic [GPIO_N-1:0] gpio_out_o;
  logic [GPIO_N-1:0] gpio_in_i;

  logic [31:0]       golden [LINES*FIELDS];
  logic [GPIO_N-1:0] exp_dir;
  logic [GPIO_N-1:0] exp_out;
  int                mismatches = 0;
  int                timeouts = 0;

  always #5 clk = ~clk;

  zd_top dut0 (
    .RSTN         (RSTN         ),
    .clk          (clk          ),
    .instr_req_i  (instr_req_i  ),
    .instr_addr_i (instr_addr_i ),
    .instr_rdata_o(instr_rdata_o),
    .instr_ack_o  (instr_ack_o  ),
    .data_req_i   (data_req_i   ),
    .data_addr_i  (data_addr_i  ),
    .data_we_i    (data_we_i    ),
    .data_mask_i  (data_mask_i  ),
    .data_wdata_i (data_wdata_i ),
    .data_rdata_o (data_rdata_o ),
    .data_ack_o   (data_ack_o   ),
    .gpio_dir_o   (gpio_dir_o   ),
    .gpio_out_o   (gpio_out_o   ),
    .gpio_in_i    (gpio_in_i    )
  );

  task automatic report_mismatch(input string tag, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("MISMATCH %s %s expected %h actual %h", tag, what, exp, act);
    mismatches++;
  endtask

  // Drive one golden line on both ports and collect both acks
  task automatic run_line(input int n);
    logic        ien;
    logic        den;
    logic        dwe;
    logic [31:0] daddr;
    logic [31:0] wdata;
    logic [31:0] exp_i;
    logic [31:0] exp_d;
    logic        i_pend;
    logic        d_pend;
    int          cycles;
    string       tag;
    ien   = golden[n*FIELDS+0][0];
    den   = golden[n*FIELDS+2][0];
    dwe   = golden[n*FIELDS+3][0];
    daddr = golden[n*FIELDS+4];
    wdata = golden[n*FIELDS+6];
    exp_i = golden[n*FIELDS+7];
    exp_d = golden[n*FIELDS+8];
    tag   = $sformatf("line %0d", n + 1);

    // GPIO outputs take the low GPIO_N bits of register writes
    if (den && dwe && (daddr[REGION_LSB +: 2] == REGION_SYS)) begin
      if (daddr[3:2] == GPREG_DIR) exp_dir = wdata[GPIO_N-1:0];
      if (daddr[3:2] == GPREG_OUT) exp_out = wdata[GPIO_N-1:0];
    end

    @(posedge clk);
    gpio_in_i    <= golden[n*FIELDS+9][GPIO_N-1:0];
    instr_req_i  <= ien;
    instr_addr_i <= golden[n*FIELDS+1][ADDR_W-1:0];
    data_req_i   <= den;
    data_we_i    <= dwe;
    data_addr_i  <= daddr[ADDR_W-1:0];
    data_mask_i  <= golden[n*FIELDS+5][MASK_W-1:0];
    data_wdata_i <= wdata;

    i_pend = ien;
    d_pend = den;
    cycles = 0;
    while ((i_pend || d_pend) && (cycles < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      if (i_pend && instr_ack_o) begin
        i_pend = 1'b0;
        if (instr_rdata_o !== exp_i) report_mismatch(tag, "instr", exp_i, instr_rdata_o);
      end
      if (d_pend && data_ack_o) begin
        d_pend = 1'b0;
        if (!dwe && (data_rdata_o !== exp_d)) begin
          report_mismatch(tag, "data", exp_d, data_rdata_o);
        end
        if (gpio_dir_o !== exp_dir) begin
          report_mismatch(tag, "gpio_dir", 32'(exp_dir), 32'(gpio_dir_o));
        end
        if (gpio_out_o !== exp_out) begin
          report_mismatch(tag, "gpio_out", 32'(exp_out), 32'(gpio_out_o));
        end
      end
      // Request drops in the cycle after its ack
      @(posedge clk);
      if (!i_pend) instr_req_i <= 1'b0;
      if (!d_pend) data_req_i <= 1'b0;
      cycles++;
    end

    if (i_pend) begin
      $display("%s: the instruction port ack never came", tag);
      timeouts++;
      instr_req_i <= 1'b0;
    end
    if (d_pend) begin
      $display("%s: the data port ack never came", tag);
      timeouts++;
      data_req_i <= 1'b0;
    end
  endtask

  initial begin
    RSTN         = 1'b0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_addr_i  = '0;
    data_we_i    = 1'b0;
    data_mask_i  = '0;
    data_wdata_i = '0;
    gpio_in_i    = '0;
    exp_dir      = '0;
    exp_out      = '0;
    $readmemh("verification/zd_golden.txt", golden);

    repeat (16) @(posedge clk);
    RSTN <= 1'b1;

    // Quiet outputs straight after reset
    @(negedge clk);
    if (instr_ack_o !== 1'b0) report_mismatch("reset", "instr_ack", 32'd0, 32'(instr_ack_o));
    if (data_ack_o !== 1'b0) report_mismatch("reset", "data_ack", 32'd0, 32'(data_ack_o));
    if (gpio_dir_o !== '0) report_mismatch("reset", "gpio_dir", 32'd0, 32'(gpio_dir_o));
    if (gpio_out_o !== '0) report_mismatch("reset", "gpio_out", 32'd0, 32'(gpio_out_o));

    for (int n = 0; n < LINES; n++) begin
      run_line(n);
    end

    $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if ((mismatches == 0) && (timeouts == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== zd_soc.f ====
design/zd_pkg.sv
design/zd_sram_bank.sv
design/zd_bank_arbiter.sv
design/zd_gpreg.sv
design/zd_xbar.sv
design/zd_top.sv
verification/zd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the fabric testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f zd_soc.f --top-module zd_tb -o zd_sim

out=$(./obj_dir/zd_sim)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1

// ==== verification/zd_golden.txt ====
// ien iaddr den dwe daddr mask wdata exp_instr exp_data gpio_in (all hex)
// exp_data is not checked on writes; exp_instr matters only when ien is 1
0 000000 1 1 000000 f 11223344 00000000 00000000 000
0 000000 1 1 010000 f 55667788 00000000 00000000 000
1 010000 1 1 000004 f a5a5a5a5 55667788 00000000 000
1 000004 1 1 000000 3 deadbeef a5a5a5a5 00000000 000
1 010000 1 0 000000 0 00000000 55667788 1122beef 000
1 000000 1 1 010000 c 99aabbcc 1122beef 00000000 000
1 010000 1 0 010000 0 00000000 99aa7788 99aa7788 000
1 000004 1 1 010010 f 0badf00d a5a5a5a5 00000000 000
1 010010 1 1 000010 f cafe0123 0badf00d 00000000 000
1 020000 1 1 030010 f ffffffff 00000000 00000000 5a3
1 030010 1 0 000010 0 00000000 00000000 cafe0123 5a3
1 000010 1 0 010010 0 00000000 cafe0123 0badf00d 5a3
1 010000 1 1 020000 f 0000f0f0 99aa7788 00000000 5a3
0 000000 1 1 020004 f 12345abc 00000000 00000000 3c6
0 000000 1 0 020004 0 00000000 00000000 00000abc 3c6
0 000000 1 0 020000 0 00000000 00000000 000000f0 3c6
0 000000 1 1 02000c f 87654321 00000000 00000000 3c6
1 000000 1 0 02000c 0 00000000 1122beef 87654321 3c6
0 000000 1 0 020008 0 00000000 00000000 000003c6 7ff
1 010010 1 0 020008 0 00000000 0badf00d 000007ff 7ff
